//--- source/elem_pkg.sv
// Element unit package.
// Widths, encodings and the structs shared by the element unit stages.

package elem_pkg;

        // ******************************
        // Widths
        // ******************************

        localparam int unsigned ID_W       = 3;
        localparam int unsigned ID_CNT     = 1 << ID_W;
        localparam int unsigned ELEM_W     = 32;
        localparam int unsigned MASK_W     = ELEM_W / 8;
        localparam int unsigned VREG_BYTES = 16;
        localparam int unsigned MUL_W      = 3;
        localparam int unsigned LOW_W      = $clog2(VREG_BYTES);
        localparam int unsigned COUNT_W    = MUL_W + LOW_W;

        // ******************************
        // Encodings
        // ******************************

        typedef enum logic [1:0] {
                EEW_8  = 2'd0,
                EEW_16 = 2'd1,
                EEW_32 = 2'd2
        } eew_e;

        typedef enum logic [1:0] {
                EMUL_1 = 2'd0,
                EMUL_2 = 2'd1,
                EMUL_4 = 2'd2,
                EMUL_8 = 2'd3
        } emul_e;

        // ******************************
        // Structs
        // ******************************

        typedef struct packed {
                logic [ID_W-1:0] id;
                eew_e            eew;
                emul_e           emul;
                logic [4:0]      vaddr;
                logic            first_cycle;
                logic            last_cycle;
                logic            xreg;
                logic [4:0]      xreg_addr;
        } elem_ctrl_t;

        // Element is right-aligned in op.
        typedef struct packed {
                elem_ctrl_t        ctrl;
                logic [ELEM_W-1:0] op;
                logic              mask;
        } elem_req_t;

        typedef struct packed {
                elem_ctrl_t        ctrl;
                logic              res_valid;
                logic [ELEM_W-1:0] res;
                logic [MASK_W-1:0] res_mask;
                logic              xreg_valid;
                logic [ELEM_W-1:0] xreg_data;
        } elem_res_t;

        // Destination byte count, also read as register index and byte index.
        typedef union packed {
                logic [COUNT_W-1:0] val;
                struct packed {
                        logic [MUL_W-1:0] mul;
                        logic [LOW_W-1:0] low;
                } part;
        } vd_count_u;

        typedef struct packed {
                logic [ID_W-1:0]   id;
                eew_e              eew;
                logic [4:0]        vaddr;
                logic              store;
                logic              shift;
                logic              valid;
                logic [ELEM_W-1:0] data;
                logic [MASK_W-1:0] mask;
                logic              pend_clear;
                emul_e             pend_clear_cnt;
                logic              instr_done;
        } vreg_out_t;

endpackage

//--- source/elem_stage.sv
// Element input stage.
// Holds one request and executes compress or move-to-scalar on it.

`timescale 1ns/100ps

module elem_stage import elem_pkg::*; (
        input  logic      clk_i,
        input  logic      reset_i,

        input  logic      in_valid_i,
        output logic      in_ready_o,
        input  elem_req_t in_req_i,

        output logic      out_valid_o,
        input  logic      out_ready_i,
        output elem_res_t out_res_o
);

        logic              valid_q;
        elem_req_t         req_q;
        logic [ELEM_W-1:0] zext;
        logic [ELEM_W-1:0] sext;
        logic [MASK_W-1:0] byte_mask;

        // Accept when empty or when the held element leaves this cycle.
        assign in_ready_o  = ~valid_q | out_ready_i;
        assign out_valid_o = valid_q;

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        valid_q <= 1'b0;
                end else if (in_valid_i & in_ready_o) begin
                        valid_q <= 1'b1;
                end else if (out_ready_i) begin
                        valid_q <= 1'b0;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_valid_i & in_ready_o) begin
                        req_q <= in_req_i;
                end
        end

        // ******************************
        // Element extension
        // ******************************

        always_comb begin
                zext      = '0;
                sext      = '0;
                byte_mask = '0;
                unique case (req_q.ctrl.eew)
                        EEW_8: begin
                                zext      = {24'b0, req_q.op[7:0]};
                                sext      = {{24{req_q.op[7]}}, req_q.op[7:0]};
                                byte_mask = 4'b0001;
                        end
                        EEW_16: begin
                                zext      = {16'b0, req_q.op[15:0]};
                                sext      = {{16{req_q.op[15]}}, req_q.op[15:0]};
                                byte_mask = 4'b0011;
                        end
                        EEW_32: begin
                                zext      = req_q.op;
                                sext      = req_q.op;
                                byte_mask = 4'b1111;
                        end
                        default: ;
                endcase
        end

        // Unused result fields stay zero.
        always_comb begin
                out_res_o            = '0;
                out_res_o.ctrl       = req_q.ctrl;
                if (req_q.ctrl.xreg) begin
                        // Only the first element goes to the scalar register.
                        out_res_o.xreg_valid = req_q.ctrl.first_cycle;
                        out_res_o.xreg_data  = sext;
                end else begin
                        out_res_o.res_valid = req_q.mask;
                        out_res_o.res       = zext;
                        out_res_o.res_mask  = byte_mask;
                end
        end

endmodule

//--- source/elem_out_stage.sv
// Element output stage.
// Counts destination bytes to place results in the register group, and
// holds back scalar results of speculative instructions.

`timescale 1ns/100ps

module elem_out_stage import elem_pkg::*; (
        input  logic              clk_i,
        input  logic              reset_i,

        input  logic              in_valid_i,
        output logic              in_ready_o,
        input  elem_res_t         in_res_i,

        input  logic [ID_CNT-1:0] instr_spec_i,
        input  logic [ID_CNT-1:0] instr_killed_i,

        output logic              out_valid_o,
        input  logic              out_ready_i,
        output vreg_out_t         out_o,

        output logic              xreg_valid_o,
        output logic [ID_W-1:0]   xreg_id_o,
        output logic [4:0]        xreg_addr_o,
        output logic [ELEM_W-1:0] xreg_data_o
);

        logic       stall;
        logic       advance;
        logic       res_valid;
        logic       first_valid;
        logic [2:0] elem_bytes;
        logic       has_valid_q;
        logic       has_valid_d;
        vd_count_u  vd_count_q;
        vd_count_u  vd_count_d;

        // ******************************
        // Handshake
        // ******************************

        // A scalar result waits until its instruction is no longer speculative.
        assign stall = in_valid_i & in_res_i.xreg_valid & instr_spec_i[in_res_i.ctrl.id];

        assign in_ready_o  = out_ready_i & ~stall;
        assign out_valid_o = in_valid_i & ~stall;
        assign advance     = in_valid_i & in_ready_o;
        assign res_valid   = in_valid_i & in_res_i.res_valid;

        // ******************************
        // Destination byte counter
        // ******************************

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        has_valid_q <= 1'b0;
                        vd_count_q  <= '0;
                end else if (advance) begin
                        has_valid_q <= has_valid_d;
                        vd_count_q  <= vd_count_d;
                end
        end

        always_comb begin
                has_valid_d = has_valid_q;
                if (in_res_i.ctrl.first_cycle) begin
                        has_valid_d = 1'b0;
                end
                if (res_valid) begin
                        has_valid_d = 1'b1;
                end
        end

        assign first_valid = res_valid & (in_res_i.ctrl.first_cycle | ~has_valid_q);

        always_comb begin
                elem_bytes = 3'd0;
                unique case (in_res_i.ctrl.eew)
                        EEW_8:   elem_bytes = 3'd1;
                        EEW_16:  elem_bytes = 3'd2;
                        EEW_32:  elem_bytes = 3'd4;
                        default: ;
                endcase
        end

        // The count points at the last byte written.
        always_comb begin
                vd_count_d.val = vd_count_q.val;
                if (res_valid) begin
                        vd_count_d.val = vd_count_q.val + COUNT_W'(elem_bytes);
                end
                if (first_valid) begin
                        vd_count_d.val = COUNT_W'(elem_bytes) - COUNT_W'(1);
                end
        end

        // ******************************
        // Vector result
        // ******************************

        always_comb begin
                out_o                = '0;
                out_o.id             = in_res_i.ctrl.id;
                out_o.eew            = in_res_i.ctrl.eew;
                out_o.valid          = res_valid;
                out_o.data           = in_res_i.res;
                out_o.mask           = in_res_i.res_mask;
                // Register is full once its last byte is written.
                out_o.store          = res_valid & ~in_res_i.ctrl.xreg &
                                       (vd_count_d.part.low == '1);
                out_o.pend_clear     = in_valid_i & in_res_i.ctrl.last_cycle &
                                       ~in_res_i.ctrl.xreg;
                out_o.pend_clear_cnt = in_res_i.ctrl.emul;
                out_o.instr_done     = in_valid_i & in_res_i.ctrl.last_cycle;

                unique case (in_res_i.ctrl.emul)
                        EMUL_1: out_o.vaddr = in_res_i.ctrl.vaddr;
                        EMUL_2: out_o.vaddr = in_res_i.ctrl.vaddr |
                                              {4'b0, vd_count_d.part.mul[0]};
                        EMUL_4: out_o.vaddr = in_res_i.ctrl.vaddr |
                                              {3'b0, vd_count_d.part.mul[1:0]};
                        EMUL_8: out_o.vaddr = in_res_i.ctrl.vaddr |
                                              {2'b0, vd_count_d.part.mul[2:0]};
                        default: ;
                endcase

                // Shift the 32-bit result word when a new word starts.
                unique case (in_res_i.ctrl.eew)
                        EEW_8:   out_o.shift = vd_count_d.val[1:0] == 2'b00;
                        EEW_16:  out_o.shift = ~vd_count_d.val[1];
                        EEW_32:  out_o.shift = 1'b1;
                        default: ;
                endcase
        end

        // ******************************
        // Scalar result
        // ******************************

        // Killed instructions drop their scalar result.
        assign xreg_valid_o = in_valid_i & in_res_i.xreg_valid & ~stall &
                              ~instr_killed_i[in_res_i.ctrl.id];
        assign xreg_id_o    = in_res_i.ctrl.id;
        assign xreg_addr_o  = in_res_i.ctrl.xreg_addr;
        assign xreg_data_o  = in_res_i.xreg_data;

endmodule

//--- source/elem_unit.sv
// Element unit top level.
// Input stage followed by the output stage with counter and speculation control.

`timescale 1ns/100ps

module elem_unit import elem_pkg::*; (
        input  logic              clk_i,
        input  logic              reset_i,

        input  logic              in_valid_i,
        output logic              in_ready_o,
        input  elem_req_t         in_req_i,

        output logic              out_valid_o,
        input  logic              out_ready_i,
        output vreg_out_t         out_o,

        input  logic [ID_CNT-1:0] instr_spec_i,
        input  logic [ID_CNT-1:0] instr_killed_i,

        output logic              xreg_valid_o,
        output logic [ID_W-1:0]   xreg_id_o,
        output logic [4:0]        xreg_addr_o,
        output logic [ELEM_W-1:0] xreg_data_o
);

        logic      stage_valid;
        logic      stage_ready;
        elem_res_t stage_res;

        elem_stage u_elem_stage (
                .clk_i       ( clk_i       ),
                .reset_i     ( reset_i     ),
                .in_valid_i  ( in_valid_i  ),
                .in_ready_o  ( in_ready_o  ),
                .in_req_i    ( in_req_i    ),
                .out_valid_o ( stage_valid ),
                .out_ready_i ( stage_ready ),
                .out_res_o   ( stage_res   )
        );

        elem_out_stage u_elem_out_stage (
                .clk_i          ( clk_i          ),
                .reset_i        ( reset_i        ),
                .in_valid_i     ( stage_valid    ),
                .in_ready_o     ( stage_ready    ),
                .in_res_i       ( stage_res      ),
                .instr_spec_i   ( instr_spec_i   ),
                .instr_killed_i ( instr_killed_i ),
                .out_valid_o    ( out_valid_o    ),
                .out_ready_i    ( out_ready_i    ),
                .out_o          ( out_o          ),
                .xreg_valid_o   ( xreg_valid_o   ),
                .xreg_id_o      ( xreg_id_o      ),
                .xreg_addr_o    ( xreg_addr_o    ),
                .xreg_data_o    ( xreg_data_o    )
        );

endmodule

//--- dv/elem_unit_checker.sv
// Element unit checker.
// Protocol assertions bound to the element unit top level.

`timescale 1ns/100ps

module elem_unit_checker import elem_pkg::*; (
        input  logic              clk_i,
        input  logic              reset_i,
        input  logic              out_valid_o,
        input  logic              out_ready_i,
        input  vreg_out_t         out_o,
        input  logic              xreg_valid_o,
        input  logic [ID_W-1:0]   xreg_id_o,
        input  logic [ID_CNT-1:0] instr_spec_i
);

        // A result that is not taken stays unchanged.
        a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
                out_valid_o && !out_ready_i |=> $stable(out_o))
                else $error("Vector result changed while held");

        a_no_spec_xreg: assert property (@(posedge clk_i) disable iff (reset_i)
                xreg_valid_o |-> !instr_spec_i[xreg_id_o])
                else $error("Scalar result left while its instruction was speculative");

        a_store_valid: assert property (@(posedge clk_i) disable iff (reset_i)
                out_o.store |-> out_valid_o)
                else $error("Store raised without a valid output");

endmodule

bind elem_unit elem_unit_checker u_elem_unit_checker (.*);

//--- dv/elem_unit_vectors.svh
// Element unit stimulus table.
// Columns: id, eew, emul, vaddr, first, last, xreg, xreg_addr, op, mask,
// spec, kill, free out_ready, expected scalar data.

localparam int ROW_CNT = 23;

row_t rows [ROW_CNT] = '{
        // Compress at EEW_8 with a mixed mask.
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  1, 0, 0, 5'd0,  32'h0000_00a1, 1, 0, 0, 0, 32'h0},
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  0, 0, 0, 5'd0,  32'h0000_00a2, 0, 0, 0, 1, 32'h0},
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  0, 0, 0, 5'd0,  32'h1234_56a3, 1, 0, 0, 0, 32'h0},
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  0, 0, 0, 5'd0,  32'h0000_00a4, 1, 0, 0, 1, 32'h0},
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  0, 0, 0, 5'd0,  32'h0000_00a5, 0, 0, 0, 0, 32'h0},
        '{3'd1, EEW_8,  EMUL_1, 5'd4,  0, 1, 0, 5'd0,  32'hffff_ffa6, 1, 0, 0, 0, 32'h0},
        // EEW_32 over a group of two registers.
        '{3'd2, EEW_32, EMUL_2, 5'd8,  1, 0, 0, 5'd0,  32'h1111_0001, 1, 0, 0, 1, 32'h0},
        '{3'd2, EEW_32, EMUL_2, 5'd8,  0, 0, 0, 5'd0,  32'h2222_0002, 1, 0, 0, 0, 32'h0},
        '{3'd2, EEW_32, EMUL_2, 5'd8,  0, 0, 0, 5'd0,  32'h3333_0003, 1, 0, 0, 1, 32'h0},
        '{3'd2, EEW_32, EMUL_2, 5'd8,  0, 0, 0, 5'd0,  32'h4444_0004, 1, 0, 0, 0, 32'h0},
        '{3'd2, EEW_32, EMUL_2, 5'd8,  0, 0, 0, 5'd0,  32'h5555_0005, 1, 0, 0, 1, 32'h0},
        '{3'd2, EEW_32, EMUL_2, 5'd8,  0, 1, 0, 5'd0,  32'h6666_0006, 1, 0, 0, 0, 32'h0},
        // EEW_16 with EMUL_8, then a restart with EMUL_4.
        '{3'd3, EEW_16, EMUL_8, 5'd16, 1, 0, 0, 5'd0,  32'hdead_8001, 1, 0, 0, 1, 32'h0},
        '{3'd3, EEW_16, EMUL_8, 5'd16, 0, 0, 0, 5'd0,  32'h0000_8002, 0, 0, 0, 0, 32'h0},
        '{3'd3, EEW_16, EMUL_8, 5'd16, 0, 1, 0, 5'd0,  32'h0000_8003, 1, 0, 0, 1, 32'h0},
        '{3'd3, EEW_16, EMUL_4, 5'd20, 1, 0, 0, 5'd0,  32'h0000_7004, 1, 0, 0, 0, 32'h0},
        '{3'd3, EEW_16, EMUL_4, 5'd20, 0, 1, 0, 5'd0,  32'h0000_7005, 1, 0, 0, 1, 32'h0},
        // Move-to-scalar at each width.
        '{3'd4, EEW_8,  EMUL_1, 5'd0,  1, 1, 1, 5'd10, 32'h0000_0085, 1, 0, 0, 0, 32'hffff_ff85},
        '{3'd4, EEW_16, EMUL_1, 5'd0,  1, 0, 1, 5'd11, 32'h1234_8001, 1, 0, 0, 1, 32'hffff_8001},
        '{3'd4, EEW_16, EMUL_1, 5'd0,  0, 1, 1, 5'd11, 32'h0000_0005, 1, 0, 0, 0, 32'h0},
        '{3'd4, EEW_32, EMUL_1, 5'd0,  1, 1, 1, 5'd12, 32'h8000_0001, 1, 0, 0, 0, 32'h8000_0001},
        // Speculative, then killed.
        '{3'd5, EEW_16, EMUL_1, 5'd0,  1, 1, 1, 5'd3,  32'h0000_7fff, 1, 1, 0, 0, 32'h0000_7fff},
        '{3'd6, EEW_8,  EMUL_1, 5'd0,  1, 1, 1, 5'd4,  32'h0000_007f, 1, 0, 1, 1, 32'h0000_007f}
};

//--- dv/elem_unit_tb.sv
// Element unit testbench.
// Applies the stimulus table and checks results against a reference byte counter.

`timescale 1ns/100ps

module elem_unit_tb import elem_pkg::*; ();

        typedef struct {
                logic [ID_W-1:0] id;
                eew_e            eew;
                emul_e           emul;
                logic [4:0]      vaddr;
                logic            first;
                logic            last;
                logic            xreg;
                logic [4:0]      xaddr;
                logic [31:0]     op;
                logic            mask;
                logic            spec;
                logic            kill;
                logic            free;
                logic [31:0]     exp_x;
        } row_t;

        `include "elem_unit_vectors.svh"

        localparam int LIMIT = 2 * ROW_CNT + 50;

        logic              clk_i = 1'b0;
        logic              reset_i;
        logic              in_valid_i;
        logic              in_ready_o;
        elem_req_t         in_req_i;
        logic              out_valid_o;
        logic              out_ready_i;
        vreg_out_t         out_o;
        logic [ID_CNT-1:0] spec;
        logic [ID_CNT-1:0] kill;
        logic              xreg_valid_o;
        logic [ID_W-1:0]   xreg_id_o;
        logic [4:0]        xreg_addr_o;
        logic [31:0]       xreg_data_o;
        integer            seed = 32'h18a7_b361;
        int                errors = 0;
        int                checks = 0;
        int                cycles = 0;
        logic              seen;
        logic [6:0]        cnt;

        elem_unit u_elem_unit (
                .clk_i          ( clk_i        ),
                .reset_i        ( reset_i      ),
                .in_valid_i     ( in_valid_i   ),
                .in_ready_o     ( in_ready_o   ),
                .in_req_i       ( in_req_i     ),
                .out_valid_o    ( out_valid_o  ),
                .out_ready_i    ( out_ready_i  ),
                .out_o          ( out_o        ),
                .instr_spec_i   ( spec         ),
                .instr_killed_i ( kill         ),
                .xreg_valid_o   ( xreg_valid_o ),
                .xreg_id_o      ( xreg_id_o    ),
                .xreg_addr_o    ( xreg_addr_o  ),
                .xreg_data_o    ( xreg_data_o  )
        );

        always #50 clk_i = ~clk_i;

        always @(posedge clk_i) begin
                cycles++;
                if (cycles > LIMIT) begin
                        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
                        $display("Simulation finished: FAIL");
                        $finish;
                end
        end

        task automatic compare(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
                checks++;
                assert (got === exp) else begin
                        errors++;
                        $display("Fail %0t %s expected %h actual %h", $time, name, exp, got);
                end
        endtask

        task automatic pick_ready(input row_t r);
                logic [31:0] rnd;
                rnd = $random(seed);
                out_ready_i = r.free ? rnd[0] : 1'b1;
        endtask

        task automatic run_row(input row_t r);
                logic        took;
                logic        wr;
                logic [2:0]  nbytes;
                logic [31:0] zext;
                logic [3:0]  bmask;
                logic        exp_shift;
                in_req_i.ctrl = '{r.id, r.eew, r.emul, r.vaddr, r.first, r.last, r.xreg, r.xaddr};
                in_req_i.op   = r.op;
                in_req_i.mask = r.mask;
                in_valid_i    = 1'b1;
                spec[r.id]    = r.spec;
                kill[r.id]    = r.kill;
                pick_ready(r);
                do begin
                        @(negedge clk_i);
                        took = in_ready_o;
                        @(posedge clk_i);
                        #10;
                        pick_ready(r);
                end while (!took);
                in_valid_i = 1'b0;
                if (r.spec) begin
                        repeat (3) begin
                                @(negedge clk_i);
                                compare("out_valid_o", out_valid_o, 0);
                                compare("xreg_valid_o", xreg_valid_o, 0);
                                compare("in_ready_o", in_ready_o, 0);
                                @(posedge clk_i);
                                #10;
                        end
                        spec[r.id] = 1'b0;
                end
                @(negedge clk_i);
                while (!(out_valid_o && out_ready_i)) begin
                        @(posedge clk_i);
                        #10;
                        pick_ready(r);
                        @(negedge clk_i);
                end
                // Reference counter points at the last byte written.
                nbytes = (r.eew == EEW_8) ? 3'd1 : (r.eew == EEW_16) ? 3'd2 : 3'd4;
                bmask  = (r.eew == EEW_8) ? 4'h1 : (r.eew == EEW_16) ? 4'h3 : 4'hf;
                zext   = r.op & {{8{bmask[3]}}, {8{bmask[2]}}, {8{bmask[1]}}, 8'hff};
                wr     = r.mask & ~r.xreg;
                if (r.first)
                        seen = 1'b0;
                if (wr) begin
                        cnt  = seen ? cnt + 7'(nbytes) : 7'(nbytes) - 7'd1;
                        seen = 1'b1;
                end
                exp_shift = (r.eew == EEW_8) ? (cnt[1:0] == 2'b00) :
                            (r.eew == EEW_16) ? ~cnt[1] : 1'b1;
                compare("out_o.valid", out_o.valid, wr);
                compare("out_o.id", out_o.id, r.id);
                compare("out_o.eew", out_o.eew, r.eew);
                compare("out_o.store", out_o.store, wr & (cnt[3:0] == 4'hf));
                if (wr) begin
                        compare("out_o.data", out_o.data, zext);
                        compare("out_o.mask", out_o.mask, bmask);
                        compare("out_o.shift", out_o.shift, exp_shift);
                        compare("out_o.vaddr", out_o.vaddr,
                                r.vaddr | (cnt[6:4] & 3'((1 << r.emul) - 1)));
                end
                compare("out_o.pend_clear", out_o.pend_clear, r.last & ~r.xreg);
                compare("out_o.pend_clear_cnt", out_o.pend_clear_cnt, r.emul);
                compare("out_o.instr_done", out_o.instr_done, r.last);
                compare("xreg_valid_o", xreg_valid_o, r.xreg & r.first & ~r.kill);
                if (r.xreg && r.first) begin
                        compare("xreg_data_o", xreg_data_o, r.exp_x);
                        compare("xreg_id_o", xreg_id_o, r.id);
                        compare("xreg_addr_o", xreg_addr_o, r.xaddr);
                end
                @(posedge clk_i);
                #10;
                kill[r.id] = 1'b0;
        endtask

        initial begin
                reset_i     = 1'b1;
                in_valid_i  = 1'b0;
                in_req_i    = '0;
                out_ready_i = 1'b1;
                spec        = '0;
                kill        = '0;
                seen        = 1'b0;
                cnt         = '0;
                repeat (5) @(posedge clk_i);
                #10;
                reset_i = 1'b0;
                @(negedge clk_i);
                compare("out_valid_o", out_valid_o, 0);
                compare("xreg_valid_o", xreg_valid_o, 0);
                compare("out_o.store", out_o.store, 0);
                compare("out_o.pend_clear", out_o.pend_clear, 0);
                @(posedge clk_i);
                #10;
                for (int i = 0; i < ROW_CNT; i++) begin
                        run_row(rows[i]);
                end
                $display("Checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

//--- compile.f
+incdir+dv
source/elem_pkg.sv
source/elem_stage.sv
source/elem_out_stage.sv
source/elem_unit.sv
dv/elem_unit_checker.sv
dv/elem_unit_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = elem_unit_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
